// ==== verilog/rvCtrl_consts.svh ====
`ifndef RVCTRL_CONSTS_SVH
`define RVCTRL_CONSTS_SVH

`define RV_XLEN         32

// major opcodes kept by the decoder
`define RV_OP_LOAD      7'b0000011
`define RV_OP_STORE     7'b0100011
`define RV_OP_IMM       7'b0010011
`define RV_OP_REG       7'b0110011
`define RV_OP_BRANCH    7'b1100011
`define RV_OP_JAL       7'b1101111
`define RV_OP_JALR      7'b1100111

`define RV_IMM_I        3'b000
`define RV_IMM_S        3'b001
`define RV_IMM_B        3'b010
`define RV_IMM_J        3'b011

`define RV_ALU_ADD      4'b0000
`define RV_ALU_SUB      4'b0001
`define RV_ALU_SLL      4'b0010
`define RV_ALU_SLT      4'b0011
`define RV_ALU_SLTU     4'b0100
`define RV_ALU_XOR      4'b0101
`define RV_ALU_SRL      4'b0110
`define RV_ALU_SRA      4'b0111
`define RV_ALU_OR       4'b1000
`define RV_ALU_AND      4'b1001

`endif

// ==== verilog/rvCtrlPkg.sv ====
`include "rvCtrl_consts.svh"

package rvCtrlPkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rType_s;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iType_s;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sType_s;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bType_s;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jType_s;

    // one fetched word, seen through every format
    typedef union packed {
        logic [`RV_XLEN-1:0] raw;
        rType_s              rType;
        iType_s              iType;
        sType_s              sType;
        bType_s              bType;
        jType_s              jType;
    } instrWord_u;

    typedef enum logic [2:0] {
        immI = `RV_IMM_I,
        immS = `RV_IMM_S,
        immB = `RV_IMM_B,
        immJ = `RV_IMM_J
    } immSrc_e;

    typedef enum logic [3:0] {
        aluAdd  = `RV_ALU_ADD,
        aluSub  = `RV_ALU_SUB,
        aluSll  = `RV_ALU_SLL,
        aluSlt  = `RV_ALU_SLT,
        aluSltu = `RV_ALU_SLTU,
        aluXor  = `RV_ALU_XOR,
        aluSrl  = `RV_ALU_SRL,
        aluSra  = `RV_ALU_SRA,
        aluOr   = `RV_ALU_OR,
        aluAnd  = `RV_ALU_AND
    } aluOp_e;

endpackage

// ==== verilog/instrLatch.sv ====
`timescale 1ns/100ps
`include "rvCtrl_consts.svh"

module instrLatch (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic [`RV_XLEN-1:0]     instrIn,
    input  logic                    instrValid,

    output rvCtrlPkg::instrWord_u   instr,
    output logic                    latchValid
);

    logic [`RV_XLEN-1:0] instrQ;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            instrQ     <= '0;
            latchValid <= 1'b0;
        end else begin
            if (instrValid) begin
                instrQ <= instrIn;        // word register loads only on a strobe
            end
            latchValid <= instrValid;     // one cycle behind the strobe
        end
    end

    assign instr.raw = instrQ;            // decoders pick their own view

    // a strobed word must be fully driven
    aKnownWord: assert property (@(posedge clk) disable iff (!arstN)
                                 instrValid |-> !$isunknown(instrIn))
        else $error("instrLatch: unknown instruction word on a strobe");

endmodule

// ==== verilog/mainDecoder.sv ====
`timescale 1ns/100ps
`include "rvCtrl_consts.svh"

module mainDecoder (
    input  rvCtrlPkg::instrWord_u   instr,

    output logic                    RegWrite,
    output rvCtrlPkg::immSrc_e      ImmSrc,
    output logic                    ALUSrc,
    output logic                    MemWrite,
    output logic                    ResultSrc,
    output logic                    Branch,
    output logic [1:0]              ALUOp,
    output logic [1:0]              J,
    output logic                    illegal
);

    import rvCtrlPkg::*;

    logic [6:0] opcode;

    assign opcode = instr.rType.opcode;

    always_comb begin
        // safe defaults that each entry below overrides
        RegWrite  = 1'b0;
        ImmSrc    = immI;
        ALUSrc    = 1'b0;
        MemWrite  = 1'b0;
        ResultSrc = 1'b0;
        Branch    = 1'b0;
        ALUOp     = 2'b00;
        J         = 2'b00;
        illegal   = 1'b0;
        case (opcode)
            `RV_OP_LOAD: begin
                RegWrite  = 1'b1;
                ALUSrc    = 1'b1;
                ResultSrc = 1'b1;             // data memory
            end
            `RV_OP_STORE: begin
                ImmSrc    = immS;
                ALUSrc    = 1'b1;
                MemWrite  = 1'b1;
            end
            `RV_OP_IMM: begin
                RegWrite  = 1'b1;
                ALUSrc    = 1'b1;
                ALUOp     = 2'b10;
            end
            `RV_OP_REG: begin
                RegWrite  = 1'b1;
                ALUOp     = 2'b10;
            end
            `RV_OP_BRANCH: begin
                ImmSrc    = immB;
                Branch    = 1'b1;
                ALUOp     = 2'b01;            // compare by subtract
            end
            `RV_OP_JAL: begin
                RegWrite  = 1'b1;
                ImmSrc    = immJ;
                J         = 2'b01;
            end
            `RV_OP_JALR: begin
                RegWrite  = 1'b1;
                ALUSrc    = 1'b1;
                ALUOp     = 2'b10;            // funct3 is 000, so add
                J         = 2'b10;
            end
            default: begin
                illegal   = 1'b1;             // lui, auipc, fence, system too
            end
        endcase
    end

endmodule

// ==== verilog/aluDecoder.sv ====
`timescale 1ns/100ps
`include "rvCtrl_consts.svh"

module aluDecoder (
    input  rvCtrlPkg::instrWord_u   instr,
    input  logic [1:0]              ALUOp,

    output rvCtrlPkg::aluOp_e       aluCtrl
);

    import rvCtrlPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    logic       isOpReg;
    logic       isOpImm;

    assign opcode   = instr.rType.opcode;
    assign funct3   = instr.rType.funct3;
    assign funct7b5 = instr.rType.funct7[5];
    assign isOpReg  = (opcode == `RV_OP_REG);
    assign isOpImm  = (opcode == `RV_OP_IMM);

    always_comb begin
        aluCtrl = aluAdd;
        case (ALUOp)
            2'b00: aluCtrl = aluAdd;      // address calc
            2'b01: aluCtrl = aluSub;      // branch compare
            2'b10: begin
                case (funct3)
                    3'b000: begin
                        // bit 30 is immediate data for addi
                        if (isOpReg && funct7b5) begin
                            aluCtrl = aluSub;
                        end else begin
                            aluCtrl = aluAdd;
                        end
                    end
                    3'b001: aluCtrl = aluSll;
                    3'b010: aluCtrl = aluSlt;
                    3'b011: aluCtrl = aluSltu;
                    3'b100: aluCtrl = aluXor;
                    3'b101: begin
                        if ((isOpReg || isOpImm) && funct7b5) begin
                            aluCtrl = aluSra;
                        end else begin
                            aluCtrl = aluSrl;
                        end
                    end
                    3'b110: aluCtrl = aluOr;
                    3'b111: aluCtrl = aluAnd;
                    default: aluCtrl = aluAdd;
                endcase
            end
            default: aluCtrl = aluAdd;    // unused class
        endcase
    end

endmodule

// ==== verilog/immExtend.sv ====
`timescale 1ns/100ps
`include "rvCtrl_consts.svh"

module immExtend (
    input  rvCtrlPkg::instrWord_u   instr,
    input  rvCtrlPkg::immSrc_e      ImmSrc,

    output logic [`RV_XLEN-1:0]     immExt
);

    import rvCtrlPkg::*;

    logic [`RV_XLEN-1:0] immIVal;
    logic [`RV_XLEN-1:0] immSVal;
    logic [`RV_XLEN-1:0] immBVal;
    logic [`RV_XLEN-1:0] immJVal;

    // sign always comes from bit 31, whatever the view calls it
    assign immIVal = {{20{instr.iType.imm12[11]}}, instr.iType.imm12};

    assign immSVal = {{20{instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};

    assign immBVal = {{19{instr.bType.imm12}},
                      instr.bType.imm12,
                      instr.bType.imm11,
                      instr.bType.imm10to5,
                      instr.bType.imm4to1,
                      1'b0};                      // halfword aligned

    assign immJVal = {{11{instr.jType.imm20}},
                      instr.jType.imm20,
                      instr.jType.imm19to12,
                      instr.jType.imm11,
                      instr.jType.imm10to1,
                      1'b0};

    always_comb begin
        case (ImmSrc)
            immI:    immExt = immIVal;
            immS:    immExt = immSVal;
            immB:    immExt = immBVal;
            immJ:    immExt = immJVal;
            default: immExt = '0;
        endcase
    end

    // the main decoder only ever selects one of the four formats
    always_comb begin
        aLegalSrc: assert final (ImmSrc inside {immI, immS, immB, immJ})
            else $error("immExtend: bad ImmSrc %b", ImmSrc);
    end

endmodule

// ==== verilog/ctrlStage.sv ====
`timescale 1ns/100ps
`include "rvCtrl_consts.svh"

module ctrlStage (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    latchValid,

    input  logic                    RegWriteDec,
    input  rvCtrlPkg::immSrc_e      ImmSrcDec,
    input  logic                    ALUSrcDec,
    input  logic                    MemWriteDec,
    input  logic                    ResultSrcDec,
    input  logic                    BranchDec,
    input  logic [1:0]              JDec,
    input  rvCtrlPkg::aluOp_e       aluCtrlDec,
    input  logic [`RV_XLEN-1:0]     immExtDec,
    input  logic                    illegalDec,

    output logic                    RegWrite,
    output rvCtrlPkg::immSrc_e      ImmSrc,
    output logic                    ALUSrc,
    output logic                    MemWrite,
    output logic                    ResultSrc,
    output logic                    Branch,
    output logic [1:0]              J,
    output rvCtrlPkg::aluOp_e       aluCtrl,
    output logic [`RV_XLEN-1:0]     immExt,
    output logic                    illegal,
    output logic                    ctrlValid
);

    import rvCtrlPkg::*;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            RegWrite  <= 1'b0;
            ImmSrc    <= immI;
            ALUSrc    <= 1'b0;
            MemWrite  <= 1'b0;
            ResultSrc <= 1'b0;
            Branch    <= 1'b0;
            J         <= 2'b00;
            aluCtrl   <= aluAdd;
            immExt    <= '0;
            illegal   <= 1'b0;
            ctrlValid <= 1'b0;
        end else begin
            ctrlValid <= latchValid;
            if (latchValid) begin                 // hold between pulses
                RegWrite  <= RegWriteDec;
                ImmSrc    <= ImmSrcDec;
                ALUSrc    <= ALUSrcDec;
                MemWrite  <= MemWriteDec;
                ResultSrc <= ResultSrcDec;
                Branch    <= BranchDec;
                J         <= JDec;
                aluCtrl   <= aluCtrlDec;
                immExt    <= immExtDec;
                illegal   <= illegalDec;
            end
        end
    end

    // a latched instruction must decode to known control
    aKnownCtrl: assert property (@(posedge clk) disable iff (!arstN)
                                 latchValid |-> !$isunknown({RegWriteDec, ImmSrcDec,
                                                            ALUSrcDec, MemWriteDec,
                                                            ResultSrcDec, BranchDec,
                                                            JDec, aluCtrlDec,
                                                            immExtDec, illegalDec}))
        else $error("ctrlStage: unknown control for a latched instruction");

endmodule

// ==== verilog/rvCtrlTop.sv ====
`timescale 1ns/100ps
`include "rvCtrl_consts.svh"

module rvCtrlTop (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic [`RV_XLEN-1:0]     instrIn,
    input  logic                    instrValid,

    output logic                    RegWrite,
    output rvCtrlPkg::immSrc_e      ImmSrc,
    output logic                    ALUSrc,
    output logic                    MemWrite,
    output logic                    ResultSrc,
    output logic                    Branch,
    output logic [1:0]              J,
    output rvCtrlPkg::aluOp_e       aluCtrl,
    output logic [`RV_XLEN-1:0]     immExt,
    output logic                    illegal,
    output logic                    ctrlValid
);

    import rvCtrlPkg::*;

    instrWord_u          instr;
    logic                latchValid;
    logic                RegWriteDec;
    immSrc_e             ImmSrcDec;
    logic                ALUSrcDec;
    logic                MemWriteDec;
    logic                ResultSrcDec;
    logic                BranchDec;
    logic [1:0]          ALUOp;           // class only, stays in here
    logic [1:0]          JDec;
    logic                illegalDec;
    aluOp_e              aluCtrlDec;
    logic [`RV_XLEN-1:0] immExtDec;

    instrLatch uLatch (
        .clk        (clk),
        .arstN      (arstN),
        .instrIn    (instrIn),
        .instrValid (instrValid),
        .instr      (instr),
        .latchValid (latchValid)
    );

    mainDecoder uMainDec (
        .instr     (instr),
        .RegWrite  (RegWriteDec),
        .ImmSrc    (ImmSrcDec),
        .ALUSrc    (ALUSrcDec),
        .MemWrite  (MemWriteDec),
        .ResultSrc (ResultSrcDec),
        .Branch    (BranchDec),
        .ALUOp     (ALUOp),
        .J         (JDec),
        .illegal   (illegalDec)
    );

    aluDecoder uAluDec (
        .instr   (instr),
        .ALUOp   (ALUOp),
        .aluCtrl (aluCtrlDec)
    );

    immExtend uImmExt (
        .instr  (instr),
        .ImmSrc (ImmSrcDec),
        .immExt (immExtDec)
    );

    ctrlStage uCtrl (
        .clk          (clk),
        .arstN        (arstN),
        .latchValid   (latchValid),
        .RegWriteDec  (RegWriteDec),
        .ImmSrcDec    (ImmSrcDec),
        .ALUSrcDec    (ALUSrcDec),
        .MemWriteDec  (MemWriteDec),
        .ResultSrcDec (ResultSrcDec),
        .BranchDec    (BranchDec),
        .JDec         (JDec),
        .aluCtrlDec   (aluCtrlDec),
        .immExtDec    (immExtDec),
        .illegalDec   (illegalDec),
        .RegWrite     (RegWrite),
        .ImmSrc       (ImmSrc),
        .ALUSrc       (ALUSrc),
        .MemWrite     (MemWrite),
        .ResultSrc    (ResultSrc),
        .Branch       (Branch),
        .J            (J),
        .aluCtrl      (aluCtrl),
        .immExt       (immExt),
        .illegal      (illegal),
        .ctrlValid    (ctrlValid)
    );

endmodule

// ==== tb/rvCtrlTb.sv ====
`timescale 1ns/100ps
`include "rvCtrl_consts.svh"

module rvCtrlTb;

    import rvCtrlPkg::*;

    logic                clk;
    logic                arstN;
    logic [`RV_XLEN-1:0] instrIn;
    logic                instrValid;

    logic                RegWrite;
    immSrc_e             ImmSrc;
    logic                ALUSrc;
    logic                MemWrite;
    logic                ResultSrc;
    logic                Branch;
    logic [1:0]          J;
    aluOp_e              aluCtrl;
    logic [`RV_XLEN-1:0] immExt;
    logic                illegal;
    logic                ctrlValid;

    logic [10:0]         actCtrl;

    logic [`RV_XLEN-1:0] patInstr[$];
    logic [10:0]         patCtrl[$];
    aluOp_e              patAlu[$];
    logic [`RV_XLEN-1:0] patImm[$];

    logic [10:0]         expCtrlQ[$];
    aluOp_e              expAluQ[$];
    logic [`RV_XLEN-1:0] expImmQ[$];
    int                  expCycleQ[$];

    int                  cycleCnt = 0;
    bit                  checkOn = 1'b0;
    int                  fd;
    int                  nRead;
    int                  waitCnt;
    int                  gap;
    string               line;
    logic [`RV_XLEN-1:0] rdInstr;
    logic [10:0]         rdCtrl;
    logic [3:0]          rdAlu;
    logic [`RV_XLEN-1:0] rdImm;

    rvCtrlTop dut (
        .clk        (clk),
        .arstN      (arstN),
        .instrIn    (instrIn),
        .instrValid (instrValid),
        .RegWrite   (RegWrite),
        .ImmSrc     (ImmSrc),
        .ALUSrc     (ALUSrc),
        .MemWrite   (MemWrite),
        .ResultSrc  (ResultSrc),
        .Branch     (Branch),
        .J          (J),
        .aluCtrl    (aluCtrl),
        .immExt     (immExt),
        .illegal    (illegal),
        .ctrlValid  (ctrlValid)
    );

    // same packing as the pattern file
    assign actCtrl = {RegWrite, ImmSrc, ALUSrc, MemWrite, ResultSrc, Branch, J, illegal};

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycleCnt <= cycleCnt + 1;

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkFlag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abortRun($sformatf("ERROR %s: expected 0x%h, got 0x%h", name, exp, act));
        end
    endtask

    task automatic checkCtrl(input string name, input logic [10:0] exp, input logic [10:0] act);
        if (act !== exp) begin
            abortRun($sformatf("ERROR %s: expected 0x%h, got 0x%h", name, exp, act));
        end
    endtask

    task automatic checkAluOp(input aluOp_e exp, input aluOp_e act);
        if (act !== exp) begin
            abortRun($sformatf("ERROR aluCtrl: expected 0x%h, got 0x%h", exp, act));
        end
    endtask

    task automatic checkImm(input logic [`RV_XLEN-1:0] exp, input logic [`RV_XLEN-1:0] act);
        if (act !== exp) begin
            abortRun($sformatf("ERROR immExt: expected 0x%h, got 0x%h", exp, act));
        end
    endtask

    task automatic sendPattern(input int idx);
        @(posedge clk);
        #2;
        instrIn    = patInstr[idx];
        instrValid = 1'b1;
        expCtrlQ.push_back(patCtrl[idx]);
        expAluQ.push_back(patAlu[idx]);
        expImmQ.push_back(patImm[idx]);
        expCycleQ.push_back(cycleCnt + 2);    // latched next edge, out one edge after that
    endtask

    task automatic idleCycle();
        @(posedge clk);
        #2;
        instrValid = 1'b0;
        instrIn    = $urandom;                // junk on the bus must be ignored
    endtask

    // output monitor samples mid cycle
    always @(negedge clk) begin
        if (arstN && checkOn) begin
            if (ctrlValid) begin
                if (expCtrlQ.size() == 0) begin
                    abortRun("ctrlValid pulsed with no instruction outstanding");
                end else begin
                    if (expCycleQ[0] != cycleCnt) begin
                        abortRun($sformatf("ctrlValid came at cycle %0d instead of cycle %0d",
                                           cycleCnt, expCycleQ[0]));
                    end
                    checkCtrl("ctrl", expCtrlQ.pop_front(), actCtrl);
                    checkAluOp(expAluQ.pop_front(), aluCtrl);
                    checkImm(expImmQ.pop_front(), immExt);
                    void'(expCycleQ.pop_front());
                end
            end else if (expCycleQ.size() != 0 && cycleCnt >= expCycleQ[0]) begin
                abortRun($sformatf("timeout, no ctrlValid by cycle %0d", expCycleQ[0]));
            end
        end
    end

    initial begin
        arstN      = 1'b0;
        instrIn    = '0;
        instrValid = 1'b0;
        void'($urandom(29200));

        fd = $fopen("tb/rvCtrl_patterns.txt", "r");
        if (fd == 0) begin
            abortRun("could not open tb/rvCtrl_patterns.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                nRead = $sscanf(line, "%h %h %h %h", rdInstr, rdCtrl, rdAlu, rdImm);
                if (nRead == 4) begin
                    patInstr.push_back(rdInstr);
                    patCtrl.push_back(rdCtrl);
                    patAlu.push_back(aluOp_e'(rdAlu));
                    patImm.push_back(rdImm);
                end
            end
        end
        $fclose(fd);
        if (patInstr.size() == 0) begin
            abortRun("pattern file holds no usable lines");
        end

        repeat (10) @(posedge clk);
        #2;
        arstN = 1'b1;

        @(negedge clk);
        checkFlag("ctrlValid", 1'b0, ctrlValid);
        checkCtrl("ctrl", 11'h000, actCtrl);    // write enables, branch, J, illegal
        checkAluOp(aluAdd, aluCtrl);
        checkImm('0, immExt);
        checkOn = 1'b1;

        // first pass strobes every cycle
        foreach (patInstr[i]) begin
            sendPattern(i);
        end
        idleCycle();
        idleCycle();

        // second pass with random idle gaps
        foreach (patInstr[i]) begin
            gap = $urandom % 4;
            repeat (gap) idleCycle();
            sendPattern(i);
        end

        waitCnt = 0;
        while (expCtrlQ.size() != 0 && waitCnt < 10) begin
            idleCycle();
            waitCnt = waitCnt + 1;
        end
        if (expCtrlQ.size() != 0) begin
            abortRun("timeout waiting for the last ctrlValid pulses");
        end
        idleCycle();

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== tb/rvCtrl_patterns.txt ====
# instr ctrl aluOp imm, all hex
# ctrl = {RegWrite, ImmSrc[2:0], ALUSrc, MemWrite, ResultSrc, Branch, J[1:0], illegal}
FFC12283 450 0 FFFFFFFC # lw   x5, -4(x2)
0081A083 450 0 00000008 # lw   x1, 8(x3)
00612623 0E0 0 0000000C # sw   x6, 12(x2)
FE70AC23 0E0 0 FFFFFFF8 # sw   x7, -8(x1)
00500093 440 0 00000005 # addi x1, x0, 5
40008113 440 0 00000400 # addi x2, x1, 1024
FFE0A213 440 3 FFFFFFFE # slti x4, x1, -2
0070B213 440 4 00000007 # sltiu x4, x1, 7
0F00C293 440 5 000000F0 # xori x5, x1, 0xf0
F000E293 440 8 FFFFFF00 # ori  x5, x1, -256
7FF0F293 440 9 000007FF # andi x5, x1, 0x7ff
00309313 440 2 00000003 # slli x6, x1, 3
0040D313 440 6 00000004 # srli x6, x1, 4
4040D313 440 7 00000404 # srai x6, x1, 4
002083B3 400 0 00000002 # add  x7, x1, x2
402083B3 400 1 00000402 # sub  x7, x1, x2
00209433 400 2 00000002 # sll  x8, x1, x2
0020A433 400 3 00000002 # slt  x8, x1, x2
0020B433 400 4 00000002 # sltu x8, x1, x2
0020C433 400 5 00000002 # xor  x8, x1, x2
0020D433 400 6 00000002 # srl  x8, x1, x2
4020D433 400 7 00000402 # sra  x8, x1, x2
0020E433 400 8 00000002 # or   x8, x1, x2
0020F433 400 9 00000002 # and  x8, x1, x2
00208863 108 1 00000010 # beq  x1, x2, +16
FE209CE3 108 1 FFFFFFF8 # bne  x1, x2, -8
0020C0E3 108 1 00000800 # blt  x1, x2, +2048
001000EF 582 0 00000800 # jal  x1, +2048
FFDFF06F 582 0 FFFFFFFC # jal  x0, -4
000010EF 582 0 00001000 # jal  x1, +4096
004280E7 444 0 00000004 # jalr x1, 4(x5)
FF408067 444 0 FFFFFFF4 # jalr x0, -12(x1)
40008067 444 0 00000400 # jalr x0, 1024(x1)
123450B7 001 0 00000123 # lui, not supported
FFFFF117 001 0 FFFFFFFF # auipc, not supported
0FF0000F 001 0 000000FF # fence, not supported
00000073 001 0 00000000 # ecall, not supported
00000000 001 0 00000000 # all zero word

// ==== rvCtrl.f ====
+incdir+verilog
verilog/rvCtrlPkg.sv
verilog/instrLatch.sv
verilog/mainDecoder.sv
verilog/aluDecoder.sv
verilog/immExtend.sv
verilog/ctrlStage.sv
verilog/rvCtrlTop.sv
tb/rvCtrlTb.sv
